// File: src/lvdcPkg.sv
package lvdcPkg;

    // **************************************************
    // word format and bit timing
    // **************************************************

    // data bits per word, sent least significant bit first.
    localparam int wordBits    = 26;
    localparam int gapBits     = 2;
    localparam int wordTimes   = wordBits + gapBits;
    localparam int bitTimeBits = 5;
    localparam int countBits   = 16;

    // **************************************************
    // host register map
    // **************************************************

    localparam int addrBits = 5;

    localparam logic [addrBits-1:0] addrOperand   = 5'h00;
    localparam logic [addrBits-1:0] addrControl   = 5'h04;
    localparam logic [addrBits-1:0] addrWordCount = 5'h08;
    localparam logic [addrBits-1:0] addrAccum     = 5'h0C;
    localparam logic [addrBits-1:0] addrStatus    = 5'h10;

    localparam logic [1:0] respOkay   = 2'd0;
    localparam logic [1:0] respSlvErr = 2'd2;

endpackage

// File: src/hostRegs.sv
`timescale 1ns/1ps
`default_nettype none

module hostRegs (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic [lvdcPkg::addrBits-1:0]   awAddr,
    input  logic                           awValid,
    output logic                           awReady,
    input  logic [31:0]                    wData,
    input  logic [3:0]                     wStrb,
    input  logic                           wValid,
    output logic                           wReady,
    output logic [1:0]                     bResp,
    output logic                           bValid,
    input  logic                           bReady,
    input  logic [lvdcPkg::addrBits-1:0]   arAddr,
    input  logic                           arValid,
    output logic                           arReady,
    output logic [31:0]                    rData,
    output logic [1:0]                     rResp,
    output logic                           rValid,
    input  logic                           rReady,
    input  logic                           running,
    input  logic                           done,
    input  logic                           carryOut,
    input  logic [lvdcPkg::wordBits-1:0]   accumSnapshot,
    output logic [lvdcPkg::wordBits-1:0]   operand,
    output logic                           subtract,
    output logic [lvdcPkg::countBits-1:0]  wordCount,
    output logic                           startReq,
    output logic                           accumLoad,
    output logic [lvdcPkg::wordBits-1:0]   accumLoadValue
);

    logic        wrFire;
    logic        rdFire;
    logic        wrMapped;
    logic [31:0] wrOld;
    logic [31:0] wrMerged;
    logic [31:0] statusWord;

    assign wrFire     = awValid && awReady && wValid && wReady;
    assign rdFire     = arValid && arReady;
    assign statusWord = {29'd0, carryOut, done, running};

    // the current value of the target register is merged with the new
    // bytes, so a partial strobe leaves the other bytes untouched.
    always_comb begin
        wrMapped = 1'b1;
        case (awAddr)
            lvdcPkg::addrOperand:   wrOld = 32'(operand);
            lvdcPkg::addrControl:   wrOld = {31'd0, subtract};
            lvdcPkg::addrWordCount: wrOld = 32'(wordCount);
            lvdcPkg::addrAccum:     wrOld = 32'(accumSnapshot);
            default: begin
                wrOld    = 32'd0;
                wrMapped = 1'b0;
            end
        endcase
        for (int i = 0; i < 4; i++) begin
            wrMerged[8*i +: 8] = wStrb[i] ? wData[8*i +: 8] : wrOld[8*i +: 8];
        end
    end

    // **************************************************
    // write channels
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b0;
        end else if (bValid) begin
            if (bReady)
                bValid <= 1'b0;
        end else if (wrFire) begin
            awReady <= 1'b0;
            wReady  <= 1'b0;
            bValid  <= 1'b1;
        end else if (awValid && wValid && !awReady) begin
            awReady <= 1'b1;
            wReady  <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wrFire) begin
            bResp <= wrMapped ? lvdcPkg::respOkay : lvdcPkg::respSlvErr;
            if (awAddr == lvdcPkg::addrAccum)
                accumLoadValue <= wrMerged[lvdcPkg::wordBits-1:0];
        end
    end

    // writes during a run are acknowledged but dropped.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            operand   <= '0;
            subtract  <= 1'b0;
            wordCount <= '0;
            startReq  <= 1'b0;
            accumLoad <= 1'b0;
        end else begin
            startReq  <= 1'b0;
            accumLoad <= 1'b0;
            if (wrFire && !running) begin
                case (awAddr)
                    lvdcPkg::addrOperand:   operand <= wrMerged[lvdcPkg::wordBits-1:0];
                    lvdcPkg::addrControl: begin
                        subtract <= wrMerged[0];
                        startReq <= wStrb[0] && wData[1];
                    end
                    lvdcPkg::addrWordCount: wordCount <= wrMerged[lvdcPkg::countBits-1:0];
                    lvdcPkg::addrAccum:     accumLoad <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // **************************************************
    // read channels
    // **************************************************

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            arReady <= 1'b0;
            rValid  <= 1'b0;
        end else if (rValid) begin
            if (rReady)
                rValid <= 1'b0;
        end else if (rdFire) begin
            arReady <= 1'b0;
            rValid  <= 1'b1;
        end else if (arValid && !arReady) begin
            arReady <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdFire) begin
            rResp <= lvdcPkg::respOkay;
            case (arAddr)
                lvdcPkg::addrOperand:   rData <= 32'(operand);
                lvdcPkg::addrControl:   rData <= {31'd0, subtract};
                lvdcPkg::addrWordCount: rData <= 32'(wordCount);
                lvdcPkg::addrAccum:     rData <= 32'(accumSnapshot);
                lvdcPkg::addrStatus:    rData <= statusWord;
                default: begin
                    rData <= 32'd0;
                    rResp <= lvdcPkg::respSlvErr;
                end
            endcase
        end
    end

endmodule
`default_nettype wire

// File: src/runControl.sv
`timescale 1ns/1ps
`default_nettype none

module runControl (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           cstN,
    input  logic                           halt,
    input  logic                           startReq,
    input  logic [lvdcPkg::countBits-1:0]  wordCount,
    input  logic                           wordEnd,
    output logic                           running,
    output logic                           done
);

    logic [1:0]                    cstSync;
    logic                          cstPrev;
    logic                          cstFall;
    logic                          startEvent;
    logic                          lastWord;
    logic [lvdcPkg::countBits-1:0] wordsDone;

    // the start button is asynchronous to the machine clock.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cstSync <= 2'b11;
            cstPrev <= 1'b1;
        end else begin
            cstSync <= {cstSync[0], cstN};
            cstPrev <= cstSync[1];
        end
    end

    assign cstFall    = cstPrev && !cstSync[1];
    assign startEvent = (startReq || cstFall) && !running;
    assign lastWord   = (wordsDone + 1'b1) == wordCount;

    // a run always ends on a word boundary, either after the last
    // programmed word or on the first boundary seen with halt high.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            running   <= 1'b0;
            done      <= 1'b0;
            wordsDone <= '0;
        end else if (startEvent) begin
            running   <= wordCount != '0;
            done      <= wordCount == '0;
            wordsDone <= '0;
        end else if (running && wordEnd) begin
            wordsDone <= wordsDone + 1'b1;
            if (lastWord || halt) begin
                running <= 1'b0;
                done    <= 1'b1;
            end
        end
    end

endmodule
`default_nettype wire

// File: src/bitTiming.sv
`timescale 1ns/1ps
`default_nettype none

module bitTiming (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             running,
    output logic [lvdcPkg::bitTimeBits-1:0]  bitTime,
    output logic                             wordStart,
    output logic                             wordEnd,
    output logic                             dataBit
);

    logic active;

    // one clock of settling after running rises, then bit time 0.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bitTime <= '0;
            active  <= 1'b0;
        end else if (!running) begin
            bitTime <= '0;
            active  <= 1'b0;
        end else if (!active) begin
            active <= 1'b1;
        end else if (bitTime == lvdcPkg::wordTimes - 1) begin
            bitTime <= '0;
        end else begin
            bitTime <= bitTime + 1'b1;
        end
    end

    // running is included so that no strobe leaks out in the clock
    // after a run has stopped.
    assign wordStart = running && active && (bitTime == 0);
    assign wordEnd   = running && active && (bitTime == lvdcPkg::wordTimes - 1);
    assign dataBit   = running && active && (bitTime < lvdcPkg::wordBits);

endmodule
`default_nettype wire

// File: src/serialArithmetic.sv
`timescale 1ns/1ps
`default_nettype none

module serialArithmetic (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          wordStart,
    input  logic                          dataBit,
    input  logic                          subtract,
    input  logic [lvdcPkg::wordBits-1:0]  operand,
    input  logic                          accBitOut,
    output logic                          accBitIn,
    output logic                          carryOut
);

    logic [lvdcPkg::wordBits-1:0] opShift;
    logic                         carry;
    logic                         carryIn;
    logic                         opBit;
    logic                         carryNext;
    logic                         dataBitPrev;

    // bit 0 comes straight from the operand register while the rest of
    // the word is loaded into the shift register.
    assign carryIn   = wordStart ? subtract : carry;
    assign opBit     = (wordStart ? operand[0] : opShift[0]) ^ subtract;
    assign accBitIn  = accBitOut ^ opBit ^ carryIn;
    assign carryNext = (accBitOut & opBit) | (carryIn & (accBitOut ^ opBit));

    always_ff @(posedge clk) begin
        if (wordStart)
            opShift <= {1'b0, operand[lvdcPkg::wordBits-1:1]};
        else if (dataBit)
            opShift <= {1'b0, opShift[lvdcPkg::wordBits-1:1]};
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            carry       <= 1'b0;
            carryOut    <= 1'b0;
            dataBitPrev <= 1'b0;
        end else begin
            dataBitPrev <= dataBit;
            if (dataBit)
                carry <= carryNext;
            // the first gap bit follows the sign bit of the sum.
            if (dataBitPrev && !dataBit)
                carryOut <= carry;
        end
    end

endmodule
`default_nettype wire

// File: src/delayLine.sv
`timescale 1ns/1ps
`default_nettype none

module delayLine (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          dataBit,
    input  logic                          wordEnd,
    input  logic                          accBitIn,
    input  logic                          accumLoad,
    input  logic [lvdcPkg::wordBits-1:0]  accumLoadValue,
    input  logic                          running,
    output logic                          accBitOut,
    output logic [lvdcPkg::wordBits-1:0]  accumSnapshot
);

    logic [lvdcPkg::wordBits-1:0] accum;
    logic                         hostLoad;

    assign hostLoad  = accumLoad && !running;
    assign accBitOut = accum[0];

    // the word leaves at bit 0 and the new sum enters at the top, so after
    // wordBits shifts the register holds the result in normal order.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            accum <= '0;
        else if (hostLoad)
            accum <= accumLoadValue;
        else if (dataBit)
            accum <= {accBitIn, accum[lvdcPkg::wordBits-1:1]};
    end

    // the loop is complete again during the gap, so wordEnd is a safe
    // point to copy it for the host.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            accumSnapshot <= '0;
        else if (hostLoad)
            accumSnapshot <= accumLoadValue;
        else if (wordEnd)
            accumSnapshot <= accum;
    end

endmodule
`default_nettype wire

// File: src/lvdc.sv
`timescale 1ns/1ps
`default_nettype none

module lvdc (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          cstN,
    input  logic                          halt,
    input  logic [lvdcPkg::addrBits-1:0]  awAddr,
    input  logic                          awValid,
    output logic                          awReady,
    input  logic [31:0]                   wData,
    input  logic [3:0]                    wStrb,
    input  logic                          wValid,
    output logic                          wReady,
    output logic [1:0]                    bResp,
    output logic                          bValid,
    input  logic                          bReady,
    input  logic [lvdcPkg::addrBits-1:0]  arAddr,
    input  logic                          arValid,
    output logic                          arReady,
    output logic [31:0]                   rData,
    output logic [1:0]                    rResp,
    output logic                          rValid,
    input  logic                          rReady
);

    // **************************************************
    // backplane nets
    // **************************************************

    logic [lvdcPkg::wordBits-1:0]    operand;
    logic                            subtract;
    logic [lvdcPkg::countBits-1:0]   wordCount;
    logic                            startReq;
    logic                            accumLoad;
    logic [lvdcPkg::wordBits-1:0]    accumLoadValue;
    logic                            running;
    logic                            done;
    logic                            wordStart;
    logic                            wordEnd;
    logic                            dataBit;
    logic                            accBitOut;
    logic                            accBitIn;
    logic                            carryOut;
    logic [lvdcPkg::wordBits-1:0]    accumSnapshot;

    hostRegs u_hostRegs (
        .clk(clk), .arstN(arstN),
        .awAddr(awAddr), .awValid(awValid), .awReady(awReady),
        .wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
        .bResp(bResp), .bValid(bValid), .bReady(bReady),
        .arAddr(arAddr), .arValid(arValid), .arReady(arReady),
        .rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
        .running(running), .done(done), .carryOut(carryOut),
        .accumSnapshot(accumSnapshot),
        .operand(operand), .subtract(subtract), .wordCount(wordCount),
        .startReq(startReq), .accumLoad(accumLoad), .accumLoadValue(accumLoadValue)
    );

    runControl u_runControl (
        .clk(clk), .arstN(arstN),
        .cstN(cstN), .halt(halt), .startReq(startReq),
        .wordCount(wordCount), .wordEnd(wordEnd),
        .running(running), .done(done)
    );

    bitTiming u_bitTiming (
        .clk(clk), .arstN(arstN), .running(running),
        .bitTime(), .wordStart(wordStart), .wordEnd(wordEnd), .dataBit(dataBit)
    );

    serialArithmetic u_serialArithmetic (
        .clk(clk), .arstN(arstN),
        .wordStart(wordStart), .dataBit(dataBit),
        .subtract(subtract), .operand(operand),
        .accBitOut(accBitOut), .accBitIn(accBitIn), .carryOut(carryOut)
    );

    delayLine u_delayLine (
        .clk(clk), .arstN(arstN),
        .dataBit(dataBit), .wordEnd(wordEnd), .accBitIn(accBitIn),
        .accumLoad(accumLoad), .accumLoadValue(accumLoadValue), .running(running),
        .accBitOut(accBitOut), .accumSnapshot(accumSnapshot)
    );

endmodule
`default_nettype wire

// File: include/lvdcTbTasks.svh
`ifndef LVDC_TB_TASKS_SVH
`define LVDC_TB_TASKS_SVH

// **************************************************
// AXI4-Lite master
// **************************************************

// every task here starts and returns 1 ns after a rising edge.
task automatic busWrite(input logic [lvdcPkg::addrBits-1:0] addr, input logic [31:0] data,
                        input logic [3:0] strb, input int stall, output logic [1:0] resp);
    int cycles;
    awAddr  = addr;
    wData   = data;
    wStrb   = strb;
    awValid = 1'b1;
    wValid  = 1'b1;
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > handshakeLimit)
            abortRun("write address and data were never accepted");
    end while (!(awReady && wReady));
    @(posedge clk);
    #1;
    awValid = 1'b0;
    wValid  = 1'b0;
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > handshakeLimit)
            abortRun("no write response arrived");
    end while (!bValid);
    resp = bResp;
    // bReady stays low here, so the response must hold.
    repeat (stall) begin
        @(negedge clk);
        checkEq("bValid", 32'(bValid), 32'd1);
        checkEq("bResp", 32'(bResp), 32'(resp));
    end
    @(posedge clk);
    #1;
    bReady = 1'b1;
    @(posedge clk);
    #1;
    bReady = 1'b0;
endtask

task automatic busRead(input logic [lvdcPkg::addrBits-1:0] addr, input int stall,
                       output logic [31:0] data, output logic [1:0] resp);
    int cycles;
    arAddr  = addr;
    arValid = 1'b1;
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > handshakeLimit)
            abortRun("read address was never accepted");
    end while (!arReady);
    @(posedge clk);
    #1;
    arValid = 1'b0;
    cycles  = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > handshakeLimit)
            abortRun("no read data arrived");
    end while (!rValid);
    data = rData;
    resp = rResp;
    repeat (stall) begin
        @(negedge clk);
        checkEq("rValid", 32'(rValid), 32'd1);
        checkEq("rData", rData, data);
    end
    @(posedge clk);
    #1;
    rReady = 1'b1;
    @(posedge clk);
    #1;
    rReady = 1'b0;
endtask

task automatic writeReg(input logic [lvdcPkg::addrBits-1:0] addr, input logic [31:0] data);
    logic [1:0] resp;
    busWrite(addr, data, 4'hF, 0, resp);
    checkEq("bResp", 32'(resp), 32'(lvdcPkg::respOkay));
endtask

task automatic readReg(input logic [lvdcPkg::addrBits-1:0] addr, output logic [31:0] data);
    logic [1:0] resp;
    busRead(addr, 0, data, resp);
    checkEq("rResp", 32'(resp), 32'(lvdcPkg::respOkay));
endtask

// polls status until done is set and running is clear.
task automatic waitDone(input int words);
    logic [31:0] status;
    int          startCycle;
    int          limitCycles;
    startCycle  = cycleCount;
    limitCycles = words * lvdcPkg::wordTimes + 100;
    do begin
        readReg(lvdcPkg::addrStatus, status);
        if (cycleCount - startCycle > limitCycles)
            abortRun("the run did not finish within its time limit");
    end while (!(status[1] && !status[0]));
endtask

task automatic pulseCst();
    cstN = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    cstN = 1'b1;
    repeat (4) @(posedge clk);
    #1;
endtask

// **************************************************
// directed tests
// **************************************************

task automatic registerAccess();
    logic [31:0] value;
    logic [1:0]  resp;
    // all handshake outputs come out of reset idle.
    checkEq("awReady", 32'(awReady), 32'd0);
    checkEq("wReady", 32'(wReady), 32'd0);
    checkEq("arReady", 32'(arReady), 32'd0);
    checkEq("bValid", 32'(bValid), 32'd0);
    checkEq("rValid", 32'(rValid), 32'd0);
    readReg(lvdcPkg::addrStatus, value);
    checkEq("status after reset", value, 32'd0);
    writeReg(lvdcPkg::addrOperand, 32'hFFFF_FFFF);
    readReg(lvdcPkg::addrOperand, value);
    checkEq("operand", value, wordMask);
    writeReg(lvdcPkg::addrControl, 32'd1);
    readReg(lvdcPkg::addrControl, value);
    checkEq("control", value, 32'd1);
    writeReg(lvdcPkg::addrControl, 32'd0);
    writeReg(lvdcPkg::addrWordCount, 32'hFFFF_FFFF);
    readReg(lvdcPkg::addrWordCount, value);
    checkEq("wordCount", value, 32'h0000_FFFF);
    writeReg(lvdcPkg::addrAccum, 32'hFFFF_FFFF);
    readReg(lvdcPkg::addrAccum, value);
    checkEq("accum", value, wordMask);
    writeReg(lvdcPkg::addrOperand, 32'h0123_4567);
    busWrite(lvdcPkg::addrOperand, 32'hAABB_CCDD, 4'b0100, 0, resp);
    checkEq("bResp", 32'(resp), 32'(lvdcPkg::respOkay));
    readReg(lvdcPkg::addrOperand, value);
    checkEq("operand after byte write", value, 32'h01BB_4567);
endtask

task automatic arithmeticRun(input logic sub, input int count);
    logic [31:0] op;
    logic [31:0] init;
    logic [31:0] expected;
    logic [31:0] value;
    op   = nextRand() & wordMask;
    init = nextRand() & wordMask;
    writeReg(lvdcPkg::addrOperand, op);
    writeReg(lvdcPkg::addrAccum, init);
    writeReg(lvdcPkg::addrWordCount, count);
    writeReg(lvdcPkg::addrControl, {30'd0, 1'b1, sub});
    waitDone(count);
    expected = sub ? init - 32'(count) * op : init + 32'(count) * op;
    readReg(lvdcPkg::addrAccum, value);
    checkEq("accum", value, expected & wordMask);
    // a borrow-free subtract leaves the carry set.
    if (sub && count == 1) begin
        readReg(lvdcPkg::addrStatus, value);
        checkEq("carryOut", 32'(value[2]), 32'(init >= op));
    end
endtask

task automatic cstStart();
    logic [31:0] op;
    logic [31:0] init;
    logic [31:0] value;
    op   = nextRand() & wordMask;
    init = nextRand() & wordMask;
    writeReg(lvdcPkg::addrOperand, op);
    writeReg(lvdcPkg::addrAccum, init);
    writeReg(lvdcPkg::addrWordCount, 32'd3);
    writeReg(lvdcPkg::addrControl, 32'd0);
    pulseCst();
    waitDone(3);
    readReg(lvdcPkg::addrAccum, value);
    checkEq("accum after cstN run", value, (init + 32'd3 * op) & wordMask);
    init = value;
    writeReg(lvdcPkg::addrWordCount, 32'd0);
    pulseCst();
    waitDone(0);
    readReg(lvdcPkg::addrAccum, value);
    checkEq("accum after zero-count run", value, init);
endtask

task automatic haltAndProtect();
    logic [31:0] op;
    logic [31:0] init;
    logic [31:0] value;
    logic [31:0] diff;
    logic [31:0] words;
    // small values keep the halted sum free of wraparound.
    op   = (nextRand() & 32'h0000_FFFF) + 32'd1;
    init = nextRand() & 32'h000F_FFFF;
    writeReg(lvdcPkg::addrOperand, op);
    writeReg(lvdcPkg::addrAccum, init);
    writeReg(lvdcPkg::addrWordCount, 32'd1000);
    writeReg(lvdcPkg::addrControl, 32'd2);
    readReg(lvdcPkg::addrStatus, value);
    checkEq("status running", 32'(value[0]), 32'd1);
    writeReg(lvdcPkg::addrOperand, op ^ 32'h0000_5555);
    writeReg(lvdcPkg::addrAccum, 32'd0);
    halt = 1'b1;
    waitDone(1000);
    halt = 1'b0;
    readReg(lvdcPkg::addrOperand, value);
    checkEq("operand after write while running", value, op);
    readReg(lvdcPkg::addrAccum, value);
    diff  = (value - init) & wordMask;
    words = diff / op;
    checkEq("halted accum remainder", diff % op, 32'd0);
    checkEq("halted word count in range", 32'(words >= 1 && words < 1000), 32'd1);
endtask

task automatic errorResponses();
    logic [31:0] value;
    logic [1:0]  resp;
    busRead(5'h14, 0, value, resp);
    checkEq("rResp unmapped", 32'(resp), 32'(lvdcPkg::respSlvErr));
    busWrite(5'h18, 32'h1234_5678, 4'hF, 0, resp);
    checkEq("bResp unmapped", 32'(resp), 32'(lvdcPkg::respSlvErr));
    busWrite(lvdcPkg::addrStatus, 32'd0, 4'hF, 0, resp);
    checkEq("bResp status write", 32'(resp), 32'(lvdcPkg::respSlvErr));
    busWrite(lvdcPkg::addrOperand, 32'h0ABC_DEF0, 4'hF, 6, resp);
    checkEq("bResp held", 32'(resp), 32'(lvdcPkg::respOkay));
    busRead(lvdcPkg::addrOperand, 6, value, resp);
    checkEq("rData held", value, 32'h0ABC_DEF0 & wordMask);
endtask

`endif

// File: testbench/lvdcTb.sv
`timescale 1ns/1ps
`default_nettype none

module lvdcTb;

    localparam int          clkPeriod      = 20;
    localparam int          handshakeLimit = 20;
    localparam logic [31:0] wordMask       = 32'h03FF_FFFF;

    logic                         clk;
    logic                         arstN;
    logic                         cstN;
    logic                         halt;
    logic [lvdcPkg::addrBits-1:0] awAddr;
    logic                         awValid;
    logic                         awReady;
    logic [31:0]                  wData;
    logic [3:0]                   wStrb;
    logic                         wValid;
    logic                         wReady;
    logic [1:0]                   bResp;
    logic                         bValid;
    logic                         bReady;
    logic [lvdcPkg::addrBits-1:0] arAddr;
    logic                         arValid;
    logic                         arReady;
    logic [31:0]                  rData;
    logic [1:0]                   rResp;
    logic                         rValid;
    logic                         rReady;
    logic [31:0]                  lcgState;
    int                           cycleCount = 0;

    lvdc u_dut (.*);

    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
        if (got !== expected)
            abortRun($sformatf("[FAIL] %0t ns: %s is 0x%0h, expected 0x%0h",
                               $time, name, got, expected));
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

`include "lvdcTbTasks.svh"

    // **************************************************
    // test sequence
    // **************************************************

    initial begin
        clk      = 1'b0;
        arstN    = 1'b0;
        cstN     = 1'b1;
        halt     = 1'b0;
        awAddr   = '0;
        awValid  = 1'b0;
        wData    = '0;
        wStrb    = '0;
        wValid   = 1'b0;
        bReady   = 1'b0;
        arAddr   = '0;
        arValid  = 1'b0;
        rReady   = 1'b0;
        lcgState = 32'h61ce_ac4c;
        repeat (3) @(posedge clk);
        #1;
        arstN = 1'b1;

        registerAccess();
        for (int n = 1; n <= 5; n++)
            arithmeticRun(1'b0, n);
        for (int n = 1; n <= 5; n++)
            arithmeticRun(1'b1, n);
        cstStart();
        haltAndProtect();
        errorResponses();

        $display("STATUS: PASS");
        $finish;
    end

endmodule
`default_nettype wire

// File: lvdc.f
+incdir+include
src/lvdcPkg.sv
src/hostRegs.sv
src/runControl.sv
src/bitTiming.sv
src/serialArithmetic.sv
src/delayLine.sv
src/lvdc.sv
testbench/lvdcTb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it.
# A $fatal in the testbench gives a nonzero exit status.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module lvdcTb -f lvdc.f -o lvdcSim
./obj_dir/lvdcSim
